/* cw_bridge.f */
bus_pkg.sv
cw_pkg.sv
cw_clk_div.sv
bus_decode.sv
cw_serializer.sv
cw_response.sv
cw_bridge_top.sv
cw_bridge_assert.sv
cw_bridge_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = cw_bridge_tb
FILELIST  = cw_bridge.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cw_bridge_tb.sv */
// testbench top for the bus to link bridge that drives master cycles and models the link peer.
`timescale 1ns/10ps

module cw_bridge_tb;

    // forty transfers of about fourteen link periods at the slowest 32-cycle period plus margin.
    localparam int MAX_CYCLES = 20000;

    // one answer of the peer for one link strobe.
    typedef struct packed {
        logic                    ack;
        logic                    err;
        logic [cw_pkg::CW_W-1:0] dat;
    } beat_t;

    logic                           i_clk = 1'b0;
    logic                           i_reset;
    logic                           i_wb_cyc;
    logic                           i_wb_stb;
    bus_pkg::bus_req_t              mreq;
    beat_t                          peer;
    logic [bus_pkg::DATA_W-1:0]     o_wb_dat;
    logic                           o_wb_ack;
    logic                           o_wb_err;
    logic [cw_pkg::CW_W-1:0]        o_cw_dat;
    logic                           o_cw_req;
    logic                           o_cw_dir;
    logic                           o_cw_clk;
    logic                           cw_prev;
    logic [31:0]                    rng = 32'ha41d_250f;
    int                             cycles = 0;
    int                             tests = 0;
    int                             checks = 0;
    int                             errors = 0;
    logic [cw_pkg::CW_W-1:0]        frame_seen[$];
    beat_t                          beats[$];

    cw_bridge_top UUT (
        .i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
        .i_wb_we(mreq.we), .i_wb_adr(mreq.adr), .i_wb_sel(mreq.sel), .i_wb_dat(mreq.dat),
        .i_cw_dat(peer.dat), .i_cw_ack(peer.ack), .i_cw_err(peer.err),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err),
        .o_cw_dat(o_cw_dat), .o_cw_req(o_cw_req), .o_cw_dir(o_cw_dir), .o_cw_clk(o_cw_clk)
    );

    always #20 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cw_prev <= o_cw_clk;
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////
    // link peer
    //////////////////////////////

    always @(posedge o_cw_clk) begin
        if (o_cw_dir && !i_reset) begin
            frame_seen.push_back(o_cw_dat);
        end
    end

    // a strobe cycle with the request up and the link turned around has used the current answer.
    always @(posedge i_clk) begin
        if (o_cw_clk && !cw_prev && o_cw_req && !o_cw_dir && beats.size() > 0) begin
            void'(beats.pop_front());
        end
        peer <= (beats.size() > 0) ? beats[0] : '0;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("Fail %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    // runs one master cycle and counts in lat the clocks from the request to the ack or err cycle.
    task automatic master_xfer(input logic we, input logic [1:0] sel, input logic [23:0] adr,
                               input logic [15:0] dat, output logic ack, output logic err,
                               output logic [15:0] rdat, output int lat);
        @(posedge i_clk);
        lat = 0;
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        mreq     <= '{we: we, sel: sel, adr: adr, dat: dat};
        do begin
            @(posedge i_clk);
            lat++;
        end while (!o_wb_ack && !o_wb_err);
        ack = o_wb_ack;
        err = o_wb_err;
        rdat = o_wb_dat;
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
    endtask

    // writes the divider with junk above the field and reads it back.
    task automatic set_divider(input logic [3:0] d);
        logic        ack;
        logic        err;
        logic [15:0] rdat;
        int          lat;
        frame_seen.delete();
        master_xfer(1'b1, 2'b11, bus_pkg::DIV_ADDR, {12'hfa0, d}, ack, err, rdat, lat);
        check(ack && !err && lat == 2, $sformatf("divider write ack after %0d clocks", lat));
        master_xfer(1'b0, 2'b11, bus_pkg::DIV_ADDR, 16'h0000, ack, err, rdat, lat);
        check(ack && lat == 2 && rdat == {12'h000, d}, $sformatf("divider read %h", rdat));
        check(!o_cw_req && frame_seen.size() == 0, "link activity during a local access");
    endtask

    task automatic wait_link_rise();
        do begin
            @(posedge i_clk);
        end while (!(o_cw_clk && !cw_prev));
    endtask

    task automatic check_period(input logic [3:0] d);
        int n;
        set_divider(d);
        wait_link_rise();
        wait_link_rise();
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!(o_cw_clk && !cw_prev));
        check(n == 2 * (d + 1), $sformatf("link clock period %0d for divider %0d", n, d));
    endtask

    // err_at picks the answer that carries err and is -1 for none.
    task automatic ext_xfer(input logic we, input logic [1:0] sel, input logic [23:0] adr,
                            input logic [15:0] dat, input int delay, input int err_at);
        logic [7:0]  exp_frame[$];
        logic [7:0]  hdr;
        logic [31:0] r;
        logic [15:0] rdat;
        logic        ack;
        logic        err;
        logic        exp_err;
        int          lat;
        int          n_beats;
        beat_t       b;
        beat_t       idle;
        hdr = 8'h00;
        hdr[cw_pkg::HDR_WE_BIT] = we;
        hdr[1:0] = sel;
        exp_frame = '{hdr, adr[23:16], adr[15:8], adr[7:0]};
        if (we) begin
            exp_frame.push_back(dat[15:8]);
            exp_frame.push_back(dat[7:0]);
        end
        r = next_random();
        idle = '0;
        n_beats = we ? 1 : 2;
        exp_err = (err_at >= 0 && err_at < n_beats);
        frame_seen.delete();
        for (int i = 0; i < n_beats; i++) begin
            repeat (delay) beats.push_back(idle);
            b.ack = (i != err_at);
            b.err = (i == err_at);
            b.dat = (i == 0) ? r[15:8] : r[7:0];
            beats.push_back(b);
            if (i == err_at) break;
        end
        master_xfer(we, sel, adr, dat, ack, err, rdat, lat);
        check(frame_seen.size() == exp_frame.size(),
              $sformatf("frame of %0d bytes, expected %0d", frame_seen.size(), exp_frame.size()));
        for (int i = 0; i < exp_frame.size() && i < frame_seen.size(); i++) begin
            check(frame_seen[i] == exp_frame[i],
                  $sformatf("frame byte %0d is %h, expected %h", i, frame_seen[i], exp_frame[i]));
        end
        check(err == exp_err && ack == !exp_err, $sformatf("ack %b err %b", ack, err));
        if (!we && !exp_err) begin
            check(rdat == r[15:0], $sformatf("read %h, expected %h", rdat, r[15:0]));
        end
        check(beats.size() == 0, "peer answers left over after the transfer");
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] s;
        logic [23:0] adr;
        i_reset  <= 1'b1;
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        mreq     <= '0;
        peer     <= '0;
        repeat (10) @(posedge i_clk);
        check(!o_wb_ack && !o_wb_err && !o_cw_req && !o_cw_dir && !o_cw_clk,
              "outputs not idle during reset");
        i_reset <= 1'b0;
        set_divider(4'd5);
        end_test("local divider access");
        check_period(4'd0);
        check_period(4'd3);
        check_period(4'd15);
        end_test("link clock divider");
        set_divider(4'd1);
        ext_xfer(1'b1, 2'b10, 24'h123456, 16'hbeef, 0, -1);
        ext_xfer(1'b1, 2'b01, 24'hfedcba, 16'h55aa, 2, -1);
        end_test("external write");
        ext_xfer(1'b0, 2'b11, 24'h001000, 16'h0000, 0, -1);
        ext_xfer(1'b0, 2'b11, 24'h001002, 16'h0000, 3, -1);
        end_test("external read");
        ext_xfer(1'b1, 2'b11, 24'h0a0b0c, 16'h1234, 1, 0);
        ext_xfer(1'b0, 2'b01, 24'h0d0e0f, 16'h0000, 0, 0);
        ext_xfer(1'b0, 2'b10, 24'h101112, 16'h0000, 2, 1);
        end_test("peer error");
        set_divider(4'd2);
        for (int k = 0; k < 40; k++) begin
            s = next_random();
            adr = s[23:0];
            if (adr == bus_pkg::DIV_ADDR) begin
                adr = adr ^ 24'h800000;
            end
            s = next_random();
            ext_xfer(s[0], s[2:1], adr, s[31:16], int'(s[4:3]),
                     (s[9:6] == 4'd0) ? int'(s[10]) : -1);
        end
        end_test("random transfers");
        errors += UUT.u_assert.fail_cnt;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* cw_bridge_assert.sv */
// bus and link protocol checks, bound to the bridge top level and counted by the testbench.
`timescale 1ns/10ps

module cw_bridge_assert (
    input logic                     i_clk,
    input logic                     i_reset,
    input logic                     i_wb_cyc,
    input logic                     i_wb_stb,
    input logic                     i_wb_ack,
    input logic                     i_wb_err,
    input logic [cw_pkg::CW_W-1:0]  i_link_dat,
    input logic                     i_link_req,
    input logic                     i_link_dir,
    input logic                     i_link_clk
);

    int fail_cnt = 0;

    a_ack_err: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wb_ack && i_wb_err))
        else begin
            $error("ack and err are high in the same cycle");
            fail_cnt++;
        end

    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_wb_ack || i_wb_err) |-> (i_wb_cyc && i_wb_stb))
        else begin
            $error("ack or err outside a master cycle");
            fail_cnt++;
        end

    // the byte may only change right after a strobe cycle, the first high cycle of the link clock.
    a_dat_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_link_dir && $past(i_link_dir) && !($past(i_link_clk) && !$past(i_link_clk, 2)))
            |-> $stable(i_link_dat))
        else begin
            $error("link byte changed between strobes");
            fail_cnt++;
        end

    a_dir_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_link_dir |-> i_link_req)
        else begin
            $error("link driven without a request");
            fail_cnt++;
        end

endmodule

bind cw_bridge_top cw_bridge_assert u_assert (
    .i_clk(i_clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
    .i_wb_ack(o_wb_ack), .i_wb_err(o_wb_err), .i_link_dat(o_cw_dat),
    .i_link_req(o_cw_req), .i_link_dir(o_cw_dir), .i_link_clk(o_cw_clk)
);

/* cw_bridge_top.sv */
// top of the bus to compressed link bridge, ties the decode, link and divider blocks together.
`timescale 1ns/10ps

module cw_bridge_top (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [bus_pkg::ADDR_W-1:0]  i_wb_adr,
    input  logic [bus_pkg::SEL_W-1:0]   i_wb_sel,
    input  logic [bus_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic [cw_pkg::CW_W-1:0]     i_cw_dat,
    input  logic                        i_cw_ack,
    input  logic                        i_cw_err,
    output logic [bus_pkg::DATA_W-1:0]  o_wb_dat,
    output logic                        o_wb_ack,
    output logic                        o_wb_err,
    output logic [cw_pkg::CW_W-1:0]     o_cw_dat,
    output logic                        o_cw_req,
    output logic                        o_cw_dir,
    output logic                        o_cw_clk
);

    bus_pkg::bus_req_t            req;
    bus_pkg::bus_rsp_t            rsp;
    logic                         req_valid;
    logic                         req_ready;
    logic                         rsp_start;
    logic                         rsp_we;
    logic                         rsp_done;
    logic                         strobe;
    logic                         div_we;
    logic [bus_pkg::DIV_W-1:0]    div_wr;
    logic [bus_pkg::DIV_W-1:0]    div_rd;

    bus_decode u_decode (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
        .i_wb_adr(i_wb_adr), .i_wb_sel(i_wb_sel), .i_wb_dat(i_wb_dat),
        .i_div(div_rd), .i_req_ready(req_ready), .i_rsp(rsp),
        .o_req(req), .o_req_valid(req_valid), .o_div_we(div_we), .o_div(div_wr),
        .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err)
    );

    cw_serializer u_serializer (
        .i_clk(i_clk), .i_reset(i_reset), .i_strobe(strobe),
        .i_req(req), .i_req_valid(req_valid), .i_rsp_done(rsp_done),
        .o_req_ready(req_ready), .o_rsp_start(rsp_start), .o_rsp_we(rsp_we),
        .o_cw_dat(o_cw_dat), .o_cw_req(o_cw_req), .o_cw_dir(o_cw_dir)
    );

    cw_response u_response (
        .i_clk(i_clk), .i_reset(i_reset), .i_strobe(strobe),
        .i_rsp_start(rsp_start), .i_rsp_we(rsp_we),
        .i_cw_dat(i_cw_dat), .i_cw_ack(i_cw_ack), .i_cw_err(i_cw_err),
        .o_rsp(rsp), .o_rsp_done(rsp_done)
    );

    cw_clk_div u_clk_div (
        .i_clk(i_clk), .i_reset(i_reset), .i_div_we(div_we), .i_div(div_wr),
        .o_div(div_rd), .o_strobe(strobe), .o_cw_clk(o_cw_clk)
    );

endmodule

/* cw_response.sv */
// collects the peer's answer on the link and forms the bus response pulse.
`timescale 1ns/10ps

module cw_response (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_strobe,
    input  logic                     i_rsp_start,
    input  logic                     i_rsp_we,
    input  logic [cw_pkg::CW_W-1:0]  i_cw_dat,
    input  logic                     i_cw_ack,
    input  logic                     i_cw_err,
    output bus_pkg::bus_rsp_t        o_rsp,
    output logic                     o_rsp_done
);

    logic                          active;
    logic                          we_q;
    logic                          hi_got;
    logic [cw_pkg::CW_W-1:0]       hi_q;
    logic                          ack_q;
    logic                          err_q;
    logic [bus_pkg::DATA_W-1:0]    dat_q;
    logic                          beat;

    // a strobe with neither ack nor err is back-pressure and simply waits.
    assign beat = active && i_strobe;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            active <= 1'b0;
            hi_got <= 1'b0;
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (i_rsp_start) begin
                active <= 1'b1;
                hi_got <= 1'b0;
            end else if (beat && i_cw_err) begin
                err_q  <= 1'b1;
                active <= 1'b0;
            end else if (beat && i_cw_ack) begin
                if (we_q || hi_got) begin
                    ack_q  <= 1'b1;
                    active <= 1'b0;
                end else begin
                    hi_got <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rsp_start) begin
            we_q <= i_rsp_we;
        end
        if (beat && i_cw_ack && !i_cw_err && !we_q) begin
            if (!hi_got) begin
                hi_q <= i_cw_dat;
            end else begin
                dat_q <= {hi_q, i_cw_dat};
            end
        end
    end

    assign o_rsp      = '{ack: ack_q, err: err_q, dat: dat_q};
    assign o_rsp_done = ack_q || err_q;

endmodule

/* cw_serializer.sv */
// shifts an accepted request out over the byte link, one byte per strobe, then hands off.
`timescale 1ns/10ps

module cw_serializer (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_strobe,
    input  bus_pkg::bus_req_t        i_req,
    input  logic                     i_req_valid,
    input  logic                     i_rsp_done,
    output logic                     o_req_ready,
    output logic                     o_rsp_start,
    output logic                     o_rsp_we,
    output logic [cw_pkg::CW_W-1:0]  o_cw_dat,
    output logic                     o_cw_req,
    output logic                     o_cw_dir
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND,
        S_RESP
    } state_t;

    state_t                       state;
    logic [cw_pkg::CNT_W-1:0]     cnt;
    logic [cw_pkg::CNT_W-1:0]     frame_len;
    logic [cw_pkg::FRAME_W-1:0]   frame_q;
    logic                         we_q;
    logic                         last;

    assign frame_len = we_q ? cw_pkg::CNT_W'(cw_pkg::WR_FRAME_LEN)
                            : cw_pkg::CNT_W'(cw_pkg::RD_FRAME_LEN);
    // every byte has been on the wire for a full link period.
    assign last = (cnt == frame_len);

    assign o_req_ready = (state == S_IDLE);
    assign o_rsp_we    = we_q;

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= S_IDLE;
            cnt         <= '0;
            o_cw_req    <= 1'b0;
            o_cw_dir    <= 1'b0;
            o_rsp_start <= 1'b0;
        end else begin
            o_rsp_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_req_valid) begin
                        state <= S_SEND;
                        cnt   <= '0;
                    end
                end
                S_SEND: begin
                    if (i_strobe) begin
                        if (last) begin
                            o_cw_dir    <= 1'b0;
                            o_rsp_start <= 1'b1;
                            state       <= S_RESP;
                        end else begin
                            o_cw_dir <= 1'b1;
                            o_cw_req <= 1'b1;
                            cnt      <= cnt + 1'b1;
                        end
                    end
                end
                S_RESP: begin
                    // the request line stays up through the whole response.
                    if (i_rsp_done) begin
                        o_cw_req <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // frame data
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_req_valid) begin
            frame_q <= {cw_pkg::cw_hdr(i_req.we, i_req.sel), i_req.adr, i_req.dat};
            we_q    <= i_req.we;
        end else if (state == S_SEND && i_strobe && !last) begin
            // most significant byte first.
            o_cw_dat <= frame_q[cw_pkg::FRAME_W-1 -: cw_pkg::CW_W];
            frame_q  <= frame_q << cw_pkg::CW_W;
        end
    end

endmodule

/* bus_decode.sv */
// master port front end, serves the divider register and forwards other transfers to the link.
`timescale 1ns/10ps

module bus_decode (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_wb_cyc,
    input  logic                        i_wb_stb,
    input  logic                        i_wb_we,
    input  logic [bus_pkg::ADDR_W-1:0]  i_wb_adr,
    input  logic [bus_pkg::SEL_W-1:0]   i_wb_sel,
    input  logic [bus_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic [bus_pkg::DIV_W-1:0]   i_div,
    input  logic                        i_req_ready,
    input  bus_pkg::bus_rsp_t           i_rsp,
    output bus_pkg::bus_req_t           o_req,
    output logic                        o_req_valid,
    output logic                        o_div_we,
    output logic [bus_pkg::DIV_W-1:0]   o_div,
    output logic [bus_pkg::DATA_W-1:0]  o_wb_dat,
    output logic                        o_wb_ack,
    output logic                        o_wb_err
);

    logic hit;
    logic go;
    logic busy;

    assign hit = (i_wb_adr == bus_pkg::DIV_ADDR);
    // a new cycle is taken only when nothing is pending or being acknowledged.
    assign go = i_wb_cyc && i_wb_stb && !busy && !o_wb_ack && !o_wb_err;

    assign o_div_we = go && hit && i_wb_we;
    assign o_div    = i_wb_dat[bus_pkg::DIV_W-1:0];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy        <= 1'b0;
            o_req_valid <= 1'b0;
            o_wb_ack    <= 1'b0;
            o_wb_err    <= 1'b0;
        end else begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            if (o_req_valid && i_req_ready) begin
                o_req_valid <= 1'b0;
            end
            if (go && hit) begin
                o_wb_ack <= 1'b1;
            end else if (go) begin
                busy        <= 1'b1;
                o_req_valid <= 1'b1;
            end
            if (busy && (i_rsp.ack || i_rsp.err)) begin
                busy     <= 1'b0;
                o_wb_ack <= i_rsp.ack;
                o_wb_err <= i_rsp.err;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (go && !hit) begin
            o_req <= '{we: i_wb_we, sel: i_wb_sel, adr: i_wb_adr, dat: i_wb_dat};
        end
        if (go && hit && !i_wb_we) begin
            o_wb_dat <= {{(bus_pkg::DATA_W-bus_pkg::DIV_W){1'b0}}, i_div};
        end else if (busy && i_rsp.ack) begin
            o_wb_dat <= i_rsp.dat;
        end
    end

endmodule

/* cw_clk_div.sv */
// programmable divider that drives the link clock and the strobe marking its rising edge.
`timescale 1ns/10ps

module cw_clk_div (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_div_we,
    input  logic [bus_pkg::DIV_W-1:0] i_div,
    output logic [bus_pkg::DIV_W-1:0] o_div,
    output logic                     o_strobe,
    output logic                     o_cw_clk
);

    logic [bus_pkg::DIV_W-1:0] div_q;
    logic [bus_pkg::DIV_W-1:0] div_act;
    logic [bus_pkg::DIV_W-1:0] cnt;
    logic                      toggle;

    // the link clock flips every div+1 cycles.
    assign toggle = (cnt == div_act);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            div_q    <= '0;
            div_act  <= '0;
            cnt      <= '0;
            o_cw_clk <= 1'b0;
            o_strobe <= 1'b0;
        end else begin
            if (i_div_we) begin
                div_q <= i_div;
            end
            // strobe is high in the first cycle the link clock is high.
            o_strobe <= toggle && !o_cw_clk;
            if (toggle) begin
                cnt      <= '0;
                o_cw_clk <= ~o_cw_clk;
                // a new divider only counts from the next half period on.
                div_act  <= div_q;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign o_div = div_q;

endmodule

/* cw_pkg.sv */
// compressed link constants and the header builder, referenced by scoped names.
package cw_pkg;

    //////////////////////////////
    // link byte and header
    //////////////////////////////

    localparam int CW_W = 8;

    // the write flag sits at the top of the header, sel at the bottom.
    localparam int HDR_WE_BIT = 7;
    localparam int HDR_SEL_W  = 2;

    //////////////////////////////
    // frames
    //////////////////////////////

    // header, three address bytes, two data bytes.
    localparam int WR_FRAME_LEN = 6;
    // header and three address bytes only.
    localparam int RD_FRAME_LEN = 4;

    localparam int FRAME_W = WR_FRAME_LEN * CW_W;
    localparam int CNT_W   = 3;

    // builds the first frame byte.
    // all bits other than we and sel stay zero.
    function automatic logic [CW_W-1:0] cw_hdr(input logic we,
                                               input logic [HDR_SEL_W-1:0] sel);
        logic [CW_W-1:0] hdr;
        hdr = '0;
        hdr[HDR_WE_BIT] = we;
        hdr[HDR_SEL_W-1:0] = sel;
        return hdr;
    endfunction

endpackage

/* bus_pkg.sv */
// master-side bus definitions shared by the bridge blocks, referenced by scoped names.
package bus_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    localparam int ADDR_W = 24;
    localparam int DATA_W = 16;
    localparam int SEL_W  = 2;

    // the divider field sits in the low bits of the local register.
    localparam int DIV_W = 4;

    // the one address the bridge answers by itself.
    localparam logic [ADDR_W-1:0] DIV_ADDR = 24'h001001;

    //////////////////////////////
    // transfer structs
    //////////////////////////////

    // a single transfer as handed from the decoder to the link side.
    typedef struct packed {
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } bus_req_t;

    // result of a link transfer.
    // ack and err are one-cycle pulses and never high together.
    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } bus_rsp_t;

endpackage
